//--- Makefile
# Verilator build and run of the packet receive core testbench

VERILATOR ?= verilator
TOP ?= tb_prism_rx_core
FILELIST ?= prism_rx_core.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary -j 0 -Wno-fatal

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- prism_rx_core.f
rx_core_pkg.sv
rx_fifo.sv
rx_mmr.sv
rx_desc_engine.sv
rx_dma_writer.sv
prism_rx_core.sv
tb_prism_rx_core.sv

//--- prism_rx_core.sv
/*
 * Packet receive core top level. Connects the descriptor and data FIFOs,
 * the register block, the descriptor engine and the DMA writer.
 */
`default_nettype none

module prism_rx_core #(
	parameter int META_DEPTH = 8,
	parameter int DATA_DEPTH = 64
) (
	input wire logic clock,
	input wire logic rst_n_i,

	// MAC side
	input wire logic meta_valid_i,
	input wire rx_core_pkg::rx_desc_t meta_i,
	output logic meta_ready_o,
	input wire logic data_valid_i,
	input wire logic [rx_core_pkg::DATA_WIDTH-1:0] data_i,
	output logic data_ready_o,

	// host register port
	input wire logic reg_valid_i,
	input wire rx_core_pkg::reg_req_t reg_i,
	output logic reg_ready_o,
	output logic rvalid_o,
	output logic [31:0] rdata_o,

	// memory write port
	output logic mem_valid_o,
	output rx_core_pkg::mem_wr_t mem_o,
	input wire logic mem_ready_i,

	output logic irq_o
);

	import rx_core_pkg::*;

	logic meta_head_valid;
	rx_desc_t meta_head;
	logic meta_pop;
	logic data_head_valid;
	logic [DATA_WIDTH-1:0] data_head;
	logic data_pop;
	logic rx_enable;
	logic [ADDR_WIDTH-1:0] desc_base;
	logic cmd_valid;
	wr_cmd_t cmd;
	logic cmd_ready;
	logic pkt_done;

	rx_fifo #(
		.payload_t(rx_desc_t),
		.DEPTH(META_DEPTH)
	) meta_fifo_inst (
		.clock,
		.rst_n_i,
		.push_valid_i(meta_valid_i),
		.push_i(meta_i),
		.push_ready_o(meta_ready_o),
		.pop_valid_o(meta_head_valid),
		.pop_o(meta_head),
		.pop_i(meta_pop)
	);

	rx_fifo #(
		.payload_t(logic [DATA_WIDTH-1:0]),
		.DEPTH(DATA_DEPTH)
	) data_fifo_inst (
		.clock,
		.rst_n_i,
		.push_valid_i(data_valid_i),
		.push_i(data_i),
		.push_ready_o(data_ready_o),
		.pop_valid_o(data_head_valid),
		.pop_o(data_head),
		.pop_i(data_pop)
	);

	rx_mmr rx_mmr_inst (
		.clock,
		.rst_n_i,
		.reg_valid_i,
		.reg_i,
		.reg_ready_o,
		.rvalid_o,
		.rdata_o,
		.pkt_done_i(pkt_done),
		.rx_enable_o(rx_enable),
		.desc_base_o(desc_base),
		.irq_o
	);

	rx_desc_engine rx_desc_engine_inst (
		.clock,
		.rst_n_i,
		.rx_enable_i(rx_enable),
		.desc_base_i(desc_base),
		.desc_valid_i(meta_head_valid),
		.desc_i(meta_head),
		.desc_pop_o(meta_pop),
		.cmd_valid_o(cmd_valid),
		.cmd_o(cmd),
		.cmd_ready_i(cmd_ready)
	);

	rx_dma_writer rx_dma_writer_inst (
		.clock,
		.rst_n_i,
		.cmd_valid_i(cmd_valid),
		.cmd_i(cmd),
		.cmd_ready_o(cmd_ready),
		.data_valid_i(data_head_valid),
		.data_i(data_head),
		.data_pop_o(data_pop),
		.mem_valid_o,
		.mem_o,
		.mem_ready_i,
		.done_o(pkt_done)
	);

endmodule

`default_nettype wire

//--- rx_core_pkg.sv
/*
 * Widths, bus structs and register map shared by the receive core.
 * Modules import it inside their body and use scoped names in their headers.
 */
`default_nettype none

package rx_core_pkg;

	// system widths
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;
	localparam int WORD_BYTES = DATA_WIDTH / 8;

	// descriptor fields, length in words and offset in bytes
	localparam int LEN_WIDTH = 8;
	localparam int OFFSET_WIDTH = 16;

	localparam int REG_IDX_WIDTH = 2;

	// one descriptor per packet, pushed by the MAC
	typedef struct packed {
		logic [LEN_WIDTH-1:0] len;
		logic [OFFSET_WIDTH-1:0] offset;
	} rx_desc_t;

	// host register request, reads and writes share one port
	typedef struct packed {
		logic write;
		logic [REG_IDX_WIDTH-1:0] index;
		logic [31:0] wdata;
	} reg_req_t;

	// single-beat memory write
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [DATA_WIDTH-1:0] data;
	} mem_wr_t;

	// command from descriptor engine to DMA writer
	typedef struct packed {
		logic [ADDR_WIDTH-1:0] addr;
		logic [LEN_WIDTH-1:0] len;
	} wr_cmd_t;

	// register map
	localparam logic [REG_IDX_WIDTH-1:0] REG_CTRL = 2'd0;
	localparam logic [REG_IDX_WIDTH-1:0] REG_BASE = 2'd1;
	localparam logic [REG_IDX_WIDTH-1:0] REG_STATUS = 2'd2;
	localparam logic [REG_IDX_WIDTH-1:0] REG_COUNT = 2'd3;

	// CTRL bit positions
	localparam int CTRL_RX_EN_BIT = 0;
	localparam int CTRL_IRQ_EN_BIT = 1;

endpackage

`default_nettype wire

//--- rx_desc_engine.sv
/*
 * Descriptor engine: pops one descriptor at a time while rx is enabled,
 * forms the buffer address from base plus offset and issues a write command.
 */
`default_nettype none

module rx_desc_engine (
	input wire logic clock,
	input wire logic rst_n_i,

	input wire logic rx_enable_i,
	input wire logic [rx_core_pkg::ADDR_WIDTH-1:0] desc_base_i,

	input wire logic desc_valid_i,
	input wire rx_core_pkg::rx_desc_t desc_i,
	output logic desc_pop_o,

	output logic cmd_valid_o,
	output rx_core_pkg::wr_cmd_t cmd_o,
	input wire logic cmd_ready_i
);

	import rx_core_pkg::*;

	logic desc_pop;
	logic cmd_valid;
	logic cmd_taken;
	wr_cmd_t cmd_q;
	logic [ADDR_WIDTH-1:0] buf_addr;

	// single command slot, refilled only after the writer has taken it
	assign desc_pop = rx_enable_i && desc_valid_i && !cmd_valid;
	assign cmd_taken = cmd_valid && cmd_ready_i;

	// base is sampled together with the descriptor
	assign buf_addr = desc_base_i + ADDR_WIDTH'(desc_i.offset);

	// clearing enable stops new pops, a held command still goes out
	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			cmd_valid <= 1'b0;
		end else if (desc_pop) begin
			cmd_valid <= 1'b1;
		end else if (cmd_taken) begin
			cmd_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (desc_pop) begin
			cmd_q.addr <= buf_addr;
			cmd_q.len <= desc_i.len;
		end
	end

	assign desc_pop_o = desc_pop;
	assign cmd_valid_o = cmd_valid;
	assign cmd_o = cmd_q;

endmodule

`default_nettype wire

//--- rx_dma_writer.sv
/*
 * DMA writer: drains the data FIFO into single-beat memory writes for one
 * command at a time and pulses done in the cycle after the final beat.
 */
`default_nettype none

module rx_dma_writer (
	input wire logic clock,
	input wire logic rst_n_i,

	input wire logic cmd_valid_i,
	input wire rx_core_pkg::wr_cmd_t cmd_i,
	output logic cmd_ready_o,

	input wire logic data_valid_i,
	input wire logic [rx_core_pkg::DATA_WIDTH-1:0] data_i,
	output logic data_pop_o,

	output logic mem_valid_o,
	output rx_core_pkg::mem_wr_t mem_o,
	input wire logic mem_ready_i,

	output logic done_o
);

	import rx_core_pkg::*;

	logic busy;
	logic done_q;
	logic [ADDR_WIDTH-1:0] addr_q;
	logic [LEN_WIDTH-1:0] remaining;
	logic cmd_accept;
	logic empty_cmd;
	logic beat;
	logic last_beat;

	assign cmd_ready_o = !busy;
	assign cmd_accept = cmd_valid_i && cmd_ready_o;
	assign empty_cmd = (cmd_i.len == '0);

	// FIFO head goes out as is, so a stalled beat stays stable
	assign mem_valid_o = busy && data_valid_i;
	assign mem_o.addr = addr_q;
	assign mem_o.data = data_i;

	assign beat = mem_valid_o && mem_ready_i;
	assign last_beat = beat && (remaining == LEN_WIDTH'(1));
	assign data_pop_o = beat;

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			busy <= 1'b0;
			remaining <= '0;
			done_q <= 1'b0;
		end else begin
			// zero-length command completes without a beat
			done_q <= last_beat || (cmd_accept && empty_cmd);
			if (cmd_accept) begin
				busy <= !empty_cmd;
				remaining <= cmd_i.len;
			end else if (beat) begin
				remaining <= remaining - 1'b1;
				if (last_beat) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// running word address
	always_ff @(posedge clock) begin
		if (cmd_accept) begin
			addr_q <= cmd_i.addr;
		end else if (beat) begin
			addr_q <= addr_q + ADDR_WIDTH'(WORD_BYTES);
		end
	end

	assign done_o = done_q;

endmodule

`default_nettype wire

//--- rx_fifo.sv
/*
 * Single-clock first-word-fall-through FIFO, payload set by a type parameter.
 * Serves as both the descriptor FIFO and the data FIFO of the receive core.
 */
`default_nettype none

module rx_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int DEPTH = 8
) (
	input wire logic clock,
	input wire logic rst_n_i,

	input wire logic push_valid_i,
	input wire payload_t push_i,
	output logic push_ready_o,

	output logic pop_valid_o,
	output payload_t pop_o,
	input wire logic pop_i
);

	localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_WIDTH = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];
	logic [PTR_WIDTH-1:0] wr_ptr;
	logic [PTR_WIDTH-1:0] rd_ptr;
	logic [CNT_WIDTH-1:0] count;
	logic do_push;
	logic do_pop;

	// pointers wrap at DEPTH, which need not be a power of two
	function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
		if (ptr == PTR_WIDTH'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign push_ready_o = (count != CNT_WIDTH'(DEPTH));
	assign pop_valid_o = (count != '0);
	assign do_push = push_valid_i && push_ready_o;
	assign do_pop = pop_i && pop_valid_o;

	// head word straight from storage
	assign pop_o = mem[rd_ptr];

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (do_push) begin
			mem[wr_ptr] <= push_i;
		end
	end

endmodule

`default_nettype wire

//--- rx_mmr.sv
/*
 * Register block of the receive core: control, DMA base, sticky status, count.
 * Reads return one cycle after the request, writes land on the accepting edge.
 */
`default_nettype none

module rx_mmr (
	input wire logic clock,
	input wire logic rst_n_i,

	input wire logic reg_valid_i,
	input wire rx_core_pkg::reg_req_t reg_i,
	output logic reg_ready_o,
	output logic rvalid_o,
	output logic [31:0] rdata_o,

	input wire logic pkt_done_i,

	output logic rx_enable_o,
	output logic [rx_core_pkg::ADDR_WIDTH-1:0] desc_base_o,
	output logic irq_o
);

	import rx_core_pkg::*;

	logic rx_enable;
	logic irq_enable;
	logic [ADDR_WIDTH-1:0] desc_base;
	logic pkt_status;
	logic [31:0] pkt_count;
	logic [31:0] read_mux;
	logic wr_en;
	logic rd_en;

	// the port never stalls
	assign reg_ready_o = 1'b1;
	assign wr_en = reg_valid_i && reg_i.write;
	assign rd_en = reg_valid_i && !reg_i.write;

	always_comb begin
		read_mux = '0;
		case (reg_i.index)
			REG_CTRL: begin
				read_mux[CTRL_RX_EN_BIT] = rx_enable;
				read_mux[CTRL_IRQ_EN_BIT] = irq_enable;
			end
			REG_BASE: read_mux = 32'(desc_base);
			REG_STATUS: read_mux[0] = pkt_status;
			default: read_mux = pkt_count;
		endcase
	end

	always_ff @(posedge clock or negedge rst_n_i) begin
		if (!rst_n_i) begin
			rx_enable <= 1'b0;
			irq_enable <= 1'b0;
			desc_base <= '0;
			pkt_status <= 1'b0;
			pkt_count <= '0;
			rvalid_o <= 1'b0;
		end else begin
			rvalid_o <= rd_en;
			if (wr_en && reg_i.index == REG_CTRL) begin
				rx_enable <= reg_i.wdata[CTRL_RX_EN_BIT];
				irq_enable <= reg_i.wdata[CTRL_IRQ_EN_BIT];
			end
			if (wr_en && reg_i.index == REG_BASE) begin
				desc_base <= ADDR_WIDTH'(reg_i.wdata);
			end
			// a completion in the same cycle as a clear keeps the bit set
			if (pkt_done_i) begin
				pkt_status <= 1'b1;
			end else if (wr_en && reg_i.index == REG_STATUS && reg_i.wdata[0]) begin
				pkt_status <= 1'b0;
			end
			if (pkt_done_i) begin
				pkt_count <= pkt_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rd_en) begin
			rdata_o <= read_mux;
		end
	end

	assign rx_enable_o = rx_enable;
	assign desc_base_o = desc_base;
	assign irq_o = pkt_status && irq_enable;

endmodule

`default_nettype wire

//--- tb_prism_rx_core.sv
/*
 * Testbench for the packet receive core: register access, enable gating,
 * random packets under memory back-pressure and the completion interrupt.
 */
`default_nettype none

module tb_prism_rx_core;

	timeunit 1ns;
	timeprecision 1ps;

	import rx_core_pkg::*;

	localparam int NUM_PACKETS = 20;
	// a packet of up to 16 words takes far less than 1000 cycles even with stalls
	localparam int TIMEOUT_CYCLES = 1000 * NUM_PACKETS;

	logic clock = 1'b0;
	logic rst_n_i;
	logic meta_valid_i;
	rx_desc_t meta_i;
	logic meta_ready_o;
	logic data_valid_i;
	logic [DATA_WIDTH-1:0] data_i;
	logic data_ready_o;
	logic reg_valid_i;
	reg_req_t reg_i;
	logic reg_ready_o;
	logic rvalid_o;
	logic [31:0] rdata_o;
	logic mem_valid_o;
	mem_wr_t mem_o;
	logic mem_ready_i;
	logic irq_o;

	// packets sent to the MAC ports, oldest first
	logic [ADDR_WIDTH-1:0] pkt_base_q[$];
	logic [OFFSET_WIDTH-1:0] pkt_offset_q[$];
	int pkt_len_q[$];
	logic [DATA_WIDTH-1:0] word_q[$];
	int word_idx = 0;
	int sent_total = 0;
	int cycle_count = 0;
	logic stalled = 1'b0;
	mem_wr_t held_beat;

	prism_rx_core #(
		.META_DEPTH(8),
		.DATA_DEPTH(64)
	) prism_rx_core_inst (
		.clock,
		.rst_n_i,
		.meta_valid_i,
		.meta_i,
		.meta_ready_o,
		.data_valid_i,
		.data_i,
		.data_ready_o,
		.reg_valid_i,
		.reg_i,
		.reg_ready_o,
		.rvalid_o,
		.rdata_o,
		.mem_valid_o,
		.mem_o,
		.mem_ready_i,
		.irq_o
	);

	always #10 clock = ~clock;

	// memory side, stalls about 30 percent of cycles
	always @(posedge clock) begin
		mem_ready_i <= ($urandom_range(99) >= 30);
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			end_with_failure();
		end
	end

	// word i of a packet lands at base + offset + i words
	function automatic mem_wr_t expected_beat(input logic [ADDR_WIDTH-1:0] base,
			input logic [OFFSET_WIDTH-1:0] offset, input int word,
			input logic [DATA_WIDTH-1:0] data);
		mem_wr_t beat;
		beat.addr = base + 32'(offset) + 32'(word) * 32'(WORD_BYTES);
		beat.data = data;
		return beat;
	endfunction

	task automatic end_with_failure();
		$display("TEST FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected 0x%0h actual 0x%0h", name, expected, actual);
			end_with_failure();
		end
	endtask

	task automatic write_reg(input logic [1:0] index, input logic [31:0] value);
		reg_req_t req;
		req.write = 1'b1;
		req.index = index;
		req.wdata = value;
		@(posedge clock);
		reg_valid_i <= 1'b1;
		reg_i <= req;
		@(posedge clock);
		reg_valid_i <= 1'b0;
	endtask

	// read data is due exactly one cycle after the accepting edge
	task automatic read_reg(input logic [1:0] index, output logic [31:0] value);
		reg_req_t req;
		req.write = 1'b0;
		req.index = index;
		req.wdata = '0;
		@(posedge clock);
		reg_valid_i <= 1'b1;
		reg_i <= req;
		@(posedge clock);
		reg_valid_i <= 1'b0;
		@(negedge clock);
		check_equal("rvalid_o", 64'd1, 64'(rvalid_o));
		value = rdata_o;
	endtask

	task automatic send_random_packet(input logic [ADDR_WIDTH-1:0] base);
		int len;
		int i;
		logic [OFFSET_WIDTH-1:0] offset;
		logic [DATA_WIDTH-1:0] word;
		rx_desc_t desc;
		logic ready;
		len = $urandom_range(16, 1);
		offset = 16'($urandom) & 16'hfffc;
		desc.len = 8'(len);
		desc.offset = offset;
		pkt_base_q.push_back(base);
		pkt_offset_q.push_back(offset);
		pkt_len_q.push_back(len);
		sent_total++;
		@(posedge clock);
		meta_valid_i <= 1'b1;
		meta_i <= desc;
		do begin
			@(negedge clock);
			ready = meta_ready_o;
			@(posedge clock);
		end while (!ready);
		meta_valid_i <= 1'b0;
		for (i = 0; i < len; i++) begin
			word = $urandom;
			word_q.push_back(word);
			data_valid_i <= 1'b1;
			data_i <= word;
			do begin
				@(negedge clock);
				ready = data_ready_o;
				@(posedge clock);
			end while (!ready);
		end
		data_valid_i <= 1'b0;
	endtask

	// the monitor pops at negedge, so poll on the other edge
	task automatic wait_drained();
		while (pkt_len_q.size() != 0) begin
			@(posedge clock);
		end
	endtask

	task automatic wait_irq();
		while (!irq_o) begin
			@(negedge clock);
		end
	endtask

	// compares every accepted beat and watches mem_o during stalls
	always @(negedge clock) begin : beat_monitor
		mem_wr_t expected;
		if (rst_n_i) begin
			if (stalled) begin
				check_equal("mem_valid_o", 64'd1, 64'(mem_valid_o));
				check_equal("mem_o", held_beat, mem_o);
			end
			if (mem_valid_o && mem_ready_i) begin
				if (pkt_len_q.size() == 0 || word_q.size() == 0) begin
					$display("memory write beat with no packet outstanding");
					end_with_failure();
				end else begin
					expected = expected_beat(pkt_base_q[0], pkt_offset_q[0], word_idx,
						word_q[0]);
					check_equal("mem_o.addr", 64'(expected.addr), 64'(mem_o.addr));
					check_equal("mem_o.data", 64'(expected.data), 64'(mem_o.data));
					void'(word_q.pop_front());
					if (word_idx == pkt_len_q[0] - 1) begin
						void'(pkt_base_q.pop_front());
						void'(pkt_offset_q.pop_front());
						void'(pkt_len_q.pop_front());
						word_idx = 0;
					end else begin
						word_idx++;
					end
				end
			end
			stalled = mem_valid_o && !mem_ready_i;
			held_beat = mem_o;
		end
	end

	initial begin
		logic [31:0] rd;
		logic [ADDR_WIDTH-1:0] base;
		rst_n_i <= 1'b0;
		meta_valid_i <= 1'b0;
		meta_i <= '0;
		data_valid_i <= 1'b0;
		data_i <= '0;
		reg_valid_i <= 1'b0;
		reg_i <= '0;
		mem_ready_i <= 1'b0;
		void'($urandom(32'hde790b66));
		repeat (10) @(posedge clock);
		rst_n_i <= 1'b1;
		@(negedge clock);

		// idle state after reset
		check_equal("mem_valid_o", 64'd0, 64'(mem_valid_o));
		check_equal("irq_o", 64'd0, 64'(irq_o));
		check_equal("rvalid_o", 64'd0, 64'(rvalid_o));
		check_equal("reg_ready_o", 64'd1, 64'(reg_ready_o));
		check_equal("meta_ready_o", 64'd1, 64'(meta_ready_o));
		check_equal("data_ready_o", 64'd1, 64'(data_ready_o));
		read_reg(REG_CTRL, rd);
		check_equal("rdata_o", 64'd0, 64'(rd));
		read_reg(REG_STATUS, rd);
		check_equal("rdata_o", 64'd0, 64'(rd));
		read_reg(REG_COUNT, rd);
		check_equal("rdata_o", 64'd0, 64'(rd));

		// register write and read back, rx still off
		base = $urandom & 32'hfffc_0000;
		write_reg(REG_BASE, base);
		read_reg(REG_BASE, rd);
		check_equal("rdata_o", 64'(base), 64'(rd));
		write_reg(REG_CTRL, 32'h2);
		read_reg(REG_CTRL, rd);
		check_equal("rdata_o", 64'h2, 64'(rd));

		// packets wait in the FIFOs until rx is enabled
		repeat (3) send_random_packet(base);
		repeat (40) begin
			@(negedge clock);
			check_equal("mem_valid_o", 64'd0, 64'(mem_valid_o));
		end
		write_reg(REG_CTRL, 32'h3);
		wait_drained();

		repeat (NUM_PACKETS) send_random_packet(base);
		wait_drained();

		// completion interrupt and packet count
		wait_irq();
		read_reg(REG_COUNT, rd);
		check_equal("rdata_o", 64'(sent_total), 64'(rd));
		write_reg(REG_STATUS, 32'h1);
		@(negedge clock);
		check_equal("irq_o", 64'd0, 64'(irq_o));
		read_reg(REG_STATUS, rd);
		check_equal("rdata_o", 64'd0, 64'(rd));
		send_random_packet(base);
		wait_drained();
		wait_irq();
		read_reg(REG_COUNT, rd);
		check_equal("rdata_o", 64'(sent_total), 64'(rd));

		if (pkt_len_q.size() != 0 || word_q.size() != 0) begin
			$display("data words left over at the end of the run");
			end_with_failure();
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
